//--- src/conv_load_pkg.sv
package conv_load_pkg;

    ////////////////////////////////////////
    // sizes
    ////////////////////////////////////////
    localparam int IDX_W              = 16;
    localparam int SA_COLUMN_NUM      = 3;
    localparam int BUFFERS_NUM        = SA_COLUMN_NUM;
    localparam int PIXELS_IN_ROW      = 32;
    localparam int PIXELS_IN_ROW_LOG2 = 5;
    localparam int DDR_LOAD_RATIO     = 2;

    ////////////////////////////////////////
    // types
    ////////////////////////////////////////

    // one layer, held for the whole load
    typedef struct packed {
        logic [IDX_W-1:0] ix;
        logic [IDX_W-1:0] iy;
        logic [IDX_W-1:0] nif;
        logic [3:0]       s;
        logic [IDX_W-1:0] seg_span;   // word length * words * spares
        logic [IDX_W-1:0] seg_words;
    } load_cfg_t;

    // counters of one walk, innermost first
    typedef struct packed {
        logic [IDX_W-1:0] tif;
        logic [IDX_W-1:0] sparex;
        logic [IDX_W-1:0] bufy;
        logic [IDX_W-1:0] siy;
        logic [IDX_W-1:0] tix;
        logic [IDX_W-1:0] tiy;
        logic [IDX_W-1:0] row_group;  // tiy steps taken
    } loop_pos_t;

    typedef struct packed {
        logic [IDX_W-1:0] row_idx;
        logic [IDX_W-1:0] row_start;
        logic [IDX_W-1:0] row_end;
        logic [IDX_W-1:0] if_start;
        logic [IDX_W-1:0] if_end;
    } load_idx_t;

    localparam loop_pos_t LOOP_POS_INIT = '{
        tif: 16'd1, sparex: 16'd1, bufy: 16'd1, siy: 16'd1,
        tix: 16'd1, tiy: 16'd1, row_group: 16'd0
    };

endpackage

//--- src/load_loop_nest.sv
`timescale 1ns/1ps

module load_loop_nest import conv_load_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  load_cfg_t cfg,
    input  logic      step,
    output loop_pos_t pos,
    output load_idx_t idx,
    output logic      tile_done,
    output logic      walk_done
);

    logic [IDX_W-1:0] s_ext;
    logic [IDX_W-1:0] s3;
    logic [IDX_W-1:0] tif_last;
    logic [IDX_W-1:0] tix_last;
    logic [IDX_W-1:0] tiy_last;
    logic [IDX_W-1:0] seg_last;

    logic tif_wrap;
    logic sparex_wrap;
    logic bufy_wrap;
    logic siy_wrap;
    logic tix_wrap;
    logic tiy_wrap;
    logic last_row;

    ////////////////////////////////////////
    // index arithmetic
    ////////////////////////////////////////
    assign s_ext = IDX_W'(cfg.s);
    assign s3    = s_ext + (s_ext << 1);

    assign tif_last = pos.tif + IDX_W'(DDR_LOAD_RATIO - 1);
    assign tix_last = pos.tix + cfg.seg_span - 1'b1;
    assign tiy_last = pos.tiy + s3 - 1'b1;

    // tiy + 3*siy - 3 + bufy - 1
    assign idx.row_idx = pos.tiy + (pos.siy << 1) + pos.siy + pos.bufy - IDX_W'(4);

    assign idx.row_start = pos.tix + (pos.sparex << PIXELS_IN_ROW_LOG2)
                         - IDX_W'(PIXELS_IN_ROW);

    assign seg_last    = idx.row_start + cfg.seg_span - 1'b1;
    assign idx.row_end = (seg_last >= cfg.ix) ? cfg.ix : seg_last;

    assign idx.if_start = pos.tif;
    assign idx.if_end   = (tif_last > cfg.nif) ? cfg.nif : tif_last;

    assign last_row = (idx.row_idx == cfg.iy);

    ////////////////////////////////////////
    // wrap cascade
    ////////////////////////////////////////
    assign tif_wrap    = step && (tif_last >= cfg.nif);
    assign sparex_wrap = tif_wrap && ((pos.sparex == cfg.seg_words) || (idx.row_end == cfg.ix));
    assign bufy_wrap   = sparex_wrap && ((pos.bufy == IDX_W'(BUFFERS_NUM)) || last_row);
    assign siy_wrap    = bufy_wrap && ((pos.siy == s_ext) || last_row);
    assign tix_wrap    = siy_wrap && (tix_last >= cfg.ix);
    assign tiy_wrap    = tix_wrap && ((tiy_last >= cfg.iy) || last_row);

    assign tile_done = siy_wrap;
    assign walk_done = tiy_wrap;

    ////////////////////////////////////////
    // counters
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            pos <= LOOP_POS_INIT;
        end else begin
            if (step) begin
                pos.tif <= tif_wrap ? IDX_W'(1) : pos.tif + IDX_W'(DDR_LOAD_RATIO);
            end
            if (tif_wrap) begin
                pos.sparex <= sparex_wrap ? IDX_W'(1) : pos.sparex + 1'b1;
            end
            if (sparex_wrap) begin
                pos.bufy <= bufy_wrap ? IDX_W'(1) : pos.bufy + 1'b1;
            end
            if (bufy_wrap) begin
                pos.siy <= siy_wrap ? IDX_W'(1) : pos.siy + 1'b1;
            end
            if (siy_wrap) begin
                pos.tix <= tix_wrap ? IDX_W'(1) : pos.tix + cfg.seg_span;
            end
            // outermost, row group counts with it
            if (tix_wrap) begin
                if (tiy_wrap) begin
                    pos.tiy       <= IDX_W'(1);
                    pos.row_group <= '0;
                end else begin
                    pos.tiy       <= pos.tiy + s3;
                    pos.row_group <= pos.row_group + 1'b1;
                end
            end
        end
    end

endmodule

//--- src/load_ddr_issuer.sv
`timescale 1ns/1ps

module load_ddr_issuer import conv_load_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  load_cfg_t cfg,
    input  logic      load_ddr_start,
    input  logic      load_ddr_continue,
    input  logic      load_tileN_fin,
    output logic      ddr_req_valid,
    output load_idx_t ddr_req,
    output logic      loading
);

    logic running;
    logic stalled;
    logic step;
    logic walk_done;

    // one request per cycle unless held by a tile stall
    assign step = running && !stalled;

    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
        end else if (load_ddr_start) begin
            running <= 1'b1;
        end else if (walk_done) begin
            running <= 1'b0;
        end
    end

    // wait for the core to drain before the next tile overwrites buffers
    always_ff @(posedge clk) begin
        if (reset) begin
            stalled <= 1'b0;
        end else if (load_tileN_fin) begin
            stalled <= 1'b1;
        end else if (load_ddr_continue) begin
            stalled <= 1'b0;
        end
    end

    load_loop_nest ddr_nest_inst (
        .clk       (clk),
        .reset     (reset),
        .cfg       (cfg),
        .step      (step),
        .pos       (),
        .idx       (ddr_req),
        .tile_done (),
        .walk_done (walk_done)
    );

    assign ddr_req_valid = step;
    assign loading       = running;

endmodule

//--- src/load_buf_writer.sv
`timescale 1ns/1ps

module load_buf_writer import conv_load_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  load_cfg_t        cfg,
    input  logic             valid_load_data,
    output logic [IDX_W-1:0] buf_idx,
    output logic [IDX_W-1:0] row_in_group,
    output load_idx_t        buf_wr,
    output logic             load_tile_fin,
    output logic             load_tile0_fin,
    output logic             load_tileN_fin
);

    loop_pos_t pos;
    logic      tile_done;

    // one step per returned beat
    load_loop_nest buf_nest_inst (
        .clk       (clk),
        .reset     (reset),
        .cfg       (cfg),
        .step      (valid_load_data),
        .pos       (pos),
        .idx       (buf_wr),
        .tile_done (tile_done),
        .walk_done ()
    );

    assign buf_idx = pos.bufy;

    ////////////////////////////////////////
    // row inside the current group
    ////////////////////////////////////////
    always_comb begin
        case (cfg.s)
            4'd1: row_in_group = pos.row_group + pos.siy;
            4'd2: row_in_group = (pos.row_group << 1) + pos.siy;
            default: row_in_group = '0;
        endcase
    end

    ////////////////////////////////////////
    // tile finish pulses
    ////////////////////////////////////////
    assign load_tile_fin = tile_done;

    // first tile of the image
    assign load_tile0_fin = tile_done
                          && (pos.tiy == IDX_W'(1))
                          && (pos.tix == IDX_W'(1));

    // interior tile, stalls the ddr side
    assign load_tileN_fin = tile_done
                          && (pos.tiy > IDX_W'(1))
                          && (pos.tix > IDX_W'(1));

endmodule

//--- src/conv_load_controller.sv
`timescale 1ns/1ps

module conv_load_controller import conv_load_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  load_cfg_t        cfg,
    input  logic             load_ddr_start,
    input  logic             load_ddr_continue,
    input  logic             valid_load_data,
    output logic             ddr_req_valid,
    output load_idx_t        ddr_req,
    output logic [IDX_W-1:0] buf_idx,
    output logic [IDX_W-1:0] row_in_group,
    output load_idx_t        buf_wr,
    output logic             load_tile_fin,
    output logic             load_tile0_fin,
    output logic             load_tileN_fin,
    output logic             loading
);

    load_cfg_t cfg_q;

    // layer config follows the input while in reset, frozen after
    always_ff @(posedge clk) begin
        if (reset) begin
            cfg_q <= cfg;
        end
    end

    load_ddr_issuer issuer_inst (
        .clk               (clk),
        .reset             (reset),
        .cfg               (cfg_q),
        .load_ddr_start    (load_ddr_start),
        .load_ddr_continue (load_ddr_continue),
        .load_tileN_fin    (load_tileN_fin),
        .ddr_req_valid     (ddr_req_valid),
        .ddr_req           (ddr_req),
        .loading           (loading)
    );

    load_buf_writer writer_inst (
        .clk             (clk),
        .reset           (reset),
        .cfg             (cfg_q),
        .valid_load_data (valid_load_data),
        .buf_idx         (buf_idx),
        .row_in_group    (row_in_group),
        .buf_wr          (buf_wr),
        .load_tile_fin   (load_tile_fin),
        .load_tile0_fin  (load_tile0_fin),
        .load_tileN_fin  (load_tileN_fin)
    );

endmodule

//--- verification/conv_load_model.svh
`ifndef CONV_LOAD_MODEL_SVH
`define CONV_LOAD_MODEL_SVH

// one expected beat on the buffer side
typedef struct packed {
    load_idx_t        wr;
    logic [IDX_W-1:0] buf_idx;
    logic [IDX_W-1:0] row_in_group;
    logic [2:0]       fin;    // tile, tile0, tileN
} beat_t;

load_idx_t exp_reqs[$];
beat_t     exp_beats[$];

function automatic load_idx_t step_indices(input load_cfg_t c, input int tif, input int sparex,
                                           input int bufy, input int siy, input int tix,
                                           input int tiy);
    load_idx_t r;
    int        last_px;
    int        last_if;
    r.row_idx   = IDX_W'(tiy + 3 * siy - 3 + bufy - 1);
    r.row_start = IDX_W'(tix + (sparex - 1) * PIXELS_IN_ROW);
    last_px     = tix + (sparex - 1) * PIXELS_IN_ROW + int'(c.seg_span) - 1;
    r.row_end   = (last_px > int'(c.ix)) ? c.ix : IDX_W'(last_px);
    r.if_start  = IDX_W'(tif);
    last_if     = tif + DDR_LOAD_RATIO - 1;
    r.if_end    = (last_if > int'(c.nif)) ? c.nif : IDX_W'(last_if);
    return r;
endfunction

// walks the six loops as plain nested loops, innermost last
task automatic build_model(input load_cfg_t c);
    int        tif, sparex, bufy, siy, tix, tiy, row_group, s;
    bit        wrap;
    load_idx_t cur;
    beat_t     b;
    exp_reqs.delete();
    exp_beats.delete();
    s         = int'(c.s);
    tiy       = 1;
    row_group = 0;
    do begin
        tix = 1;
        do begin
            siy = 1;
            do begin
                bufy = 1;
                do begin
                    sparex = 1;
                    do begin
                        tif = 1;
                        do begin
                            cur = step_indices(c, tif, sparex, bufy, siy, tix, tiy);
                            exp_reqs.push_back(cur);
                            b         = '0;
                            b.wr      = cur;
                            b.buf_idx = IDX_W'(bufy);
                            if (s == 1)
                                b.row_in_group = IDX_W'(row_group + siy);
                            else if (s == 2)
                                b.row_in_group = IDX_W'(2 * row_group + siy);
                            exp_beats.push_back(b);
                            wrap = (tif + DDR_LOAD_RATIO - 1 >= int'(c.nif));
                            tif += DDR_LOAD_RATIO;
                        end while (!wrap);
                        wrap = (sparex == int'(c.seg_words)) || (cur.row_end == c.ix);
                        sparex++;
                    end while (!wrap);
                    wrap = (bufy == BUFFERS_NUM) || (cur.row_idx == c.iy);
                    bufy++;
                end while (!wrap);
                wrap = (siy == s) || (cur.row_idx == c.iy);
                siy++;
            end while (!wrap);
            // the beat that closes the stride rows ends a tile
            b     = exp_beats[exp_beats.size() - 1];
            b.fin = {1'b1, (tiy == 1) && (tix == 1), (tiy > 1) && (tix > 1)};
            exp_beats[exp_beats.size() - 1] = b;
            wrap = (tix + int'(c.seg_span) - 1 >= int'(c.ix));
            tix += int'(c.seg_span);
        end while (!wrap);
        wrap = (tiy + 3 * s - 1 >= int'(c.iy)) || (cur.row_idx == c.iy);
        tiy += 3 * s;
        row_group++;
    end while (!wrap);
endtask

`endif

//--- verification/conv_load_tb.sv
`timescale 1ns/1ps

module conv_load_tb import conv_load_pkg::*; ();

    localparam int RUNS           = 6;
    localparam int TIMEOUT_FACTOR = 30;

    logic             clk;
    logic             reset;
    load_cfg_t        cfg;
    logic             load_ddr_start;
    logic             load_ddr_continue;
    logic             valid_load_data;
    logic             ddr_req_valid;
    load_idx_t        ddr_req;
    logic [IDX_W-1:0] buf_idx;
    logic [IDX_W-1:0] row_in_group;
    load_idx_t        buf_wr;
    logic             load_tile_fin;
    logic             load_tile0_fin;
    logic             load_tileN_fin;
    logic             loading;

    integer    seed = 32'h8cc7_0296;
    load_cfg_t run_cfg [RUNS];
    int        run_no = 0;
    int        watchdog_cycles = 0;

    // what the next cycle should look like
    bit exp_loading;
    bit exp_stall;
    bit start_sent;
    int pending;
    int req_count;
    int cont_delay;
    int idle_left;

    `include "conv_load_model.svh"

    conv_load_controller conv_load_controller_inst (
        .clk               (clk),
        .reset             (reset),
        .cfg               (cfg),
        .load_ddr_start    (load_ddr_start),
        .load_ddr_continue (load_ddr_continue),
        .valid_load_data   (valid_load_data),
        .ddr_req_valid     (ddr_req_valid),
        .ddr_req           (ddr_req),
        .buf_idx           (buf_idx),
        .row_in_group      (row_in_group),
        .buf_wr            (buf_wr),
        .load_tile_fin     (load_tile_fin),
        .load_tile0_fin    (load_tile0_fin),
        .load_tileN_fin    (load_tileN_fin),
        .loading           (loading)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [95:0] expected,
                               input logic [95:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s in run %0d: expected %0h, actual %0h",
                     name, run_no, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    task automatic draw_config(output load_cfg_t c);
        c           = '0;
        c.s         = 4'(rand_range(1, 2));
        c.ix        = IDX_W'(rand_range(8, 100));
        c.iy        = IDX_W'(rand_range(4, 20));
        c.nif       = IDX_W'(rand_range(1, 6));
        c.seg_words = IDX_W'(rand_range(1, 2));
        c.seg_span  = IDX_W'(int'(c.seg_words) * PIXELS_IN_ROW);
    endtask

    ////////////////////////////////////////
    // falling edge drives start, continue and ddr beats
    ////////////////////////////////////////
    task automatic drive_cycle();
        load_ddr_start    = 1'b0;
        load_ddr_continue = 1'b0;
        valid_load_data   = 1'b0;
        if (!start_sent) begin
            if (idle_left == 0) begin
                load_ddr_start = 1'b1;
                start_sent     = 1'b1;
            end else begin
                idle_left--;
            end
        end
        if (cont_delay > 0) begin
            cont_delay--;
            if (cont_delay == 0)
                load_ddr_continue = 1'b1;
        end
        // ddr stand-in returns roughly three beats in four cycles
        if (pending > 0 && rand_range(0, 3) != 0) begin
            valid_load_data = 1'b1;
            pending--;
        end
    endtask

    ////////////////////////////////////////
    // rising edge checks against the model
    ////////////////////////////////////////
    task automatic check_cycle();
        load_idx_t exp_req;
        beat_t     exp_beat;
        logic      exp_valid;
        exp_valid = exp_loading && !exp_stall;
        exp_beat  = '0;
        check_value("ddr_req_valid", exp_valid, ddr_req_valid);
        check_value("loading", exp_loading, loading);
        if (exp_valid) begin
            exp_req = exp_reqs.pop_front();
            check_value("ddr_req", exp_req, ddr_req);
        end
        if (ddr_req_valid) begin
            req_count++;
            pending++;
        end
        if (valid_load_data) begin
            exp_beat = exp_beats.pop_front();
            check_value("buf_wr", exp_beat.wr, buf_wr);
            check_value("buf_idx", exp_beat.buf_idx, buf_idx);
            check_value("row_in_group", exp_beat.row_in_group, row_in_group);
        end
        check_value("tile fin pulses", exp_beat.fin,
                    {load_tile_fin, load_tile0_fin, load_tileN_fin});
        if (load_ddr_start)
            exp_loading = 1'b1;
        if (exp_valid && exp_reqs.size() == 0)
            exp_loading = 1'b0;
        // tileN beat wins over a continue in the same cycle
        if (exp_beat.fin[0]) begin
            exp_stall  = 1'b1;
            cont_delay = rand_range(1, 8);
        end else if (load_ddr_continue) begin
            exp_stall = 1'b0;
        end
    endtask

    task automatic run_load(input load_cfg_t c);
        int total;
        build_model(c);
        total             = exp_reqs.size();
        reset             = 1'b1;
        cfg               = c;
        load_ddr_start    = 1'b0;
        load_ddr_continue = 1'b0;
        valid_load_data   = 1'b0;
        repeat (10) @(negedge clk);
        reset       = 1'b0;
        exp_loading = 1'b0;
        exp_stall   = 1'b0;
        start_sent  = 1'b0;
        pending     = 0;
        req_count   = 0;
        cont_delay  = 0;
        idle_left   = rand_range(1, 4);
        do begin
            drive_cycle();
            @(posedge clk);
            check_cycle();
            @(negedge clk);
        end while (!(start_sent && !exp_loading && pending == 0 && cont_delay == 0
                     && exp_beats.size() == 0));
        check_value("request count", total, req_count);
    endtask

    initial begin
        int budget;
        reset             = 1'b1;
        cfg               = '0;
        load_ddr_start    = 1'b0;
        load_ddr_continue = 1'b0;
        valid_load_data   = 1'b0;
        budget            = 0;
        for (int r = 0; r < RUNS; r++) begin
            draw_config(run_cfg[r]);
            build_model(run_cfg[r]);
            budget += (exp_reqs.size() + 16) * TIMEOUT_FACTOR;
        end
        watchdog_cycles = budget;
        @(negedge clk);
        for (int r = 0; r < RUNS; r++) begin
            run_no = r;
            run_load(run_cfg[r]);
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

    // watchdog
    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: load never finished within %0d cycles", watchdog_cycles);
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- files.f
+incdir+verification
src/conv_load_pkg.sv
src/load_loop_nest.sv
src/load_ddr_issuer.sv
src/load_buf_writer.sv
src/conv_load_controller.sv
verification/conv_load_tb.sv
